//--- hdl/config_capture.sv
// DIP bytes beyond index 7 are dropped; the tank flag follows the last game byte only
`include "sys1_settings.svh"

module config_capture
	import sys1_pkg::*;
(
	input  logic                                clk_sys,
	input  logic                                reset,
	input  logic                                ioctl_wr,
	input  logic [7:0]                          ioctl_index,
	input  logic [`SYS1_DL_ADDR_W-1:0]          ioctl_addr,
	input  logic [7:0]                          ioctl_dout,
	output logic [8*`SYS1_DIP_BYTES-1:0]        dip_switches,
	output game_type_t                          game_type,
	output logic                                tank_mode
);

	logic dip_wr;   // Byte for a DIP lane
	logic game_wr;  // Game type byte

	assign dip_wr  = ioctl_wr && (ioctl_index == `SYS1_IDX_DIP) &&
			(ioctl_addr < `SYS1_DIP_BYTES);
	assign game_wr = ioctl_wr && (ioctl_index == `SYS1_IDX_GAME);

	// ############################################################
	// DIP switches, byte n in lane n
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			dip_switches <= '0;
		end else if (dip_wr) begin
			dip_switches[8*ioctl_addr[2:0] +: 8] <= ioctl_dout;
		end
	end

	// Game type and control scheme
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			game_type <= `SYS1_GAME_DEFAULT;
			tank_mode <= (`SYS1_GAME_DEFAULT == `SYS1_GAME_TANK);
		end else if (game_wr) begin
			game_type <= ioctl_dout;
			// Decoded from the incoming byte so it lines up with game_type
			tank_mode <= (ioctl_dout == `SYS1_GAME_TANK);
		end
	end

endmodule

//--- hdl/key_mapper.sv
// Expects one ps2_key toggle per event; keys held across a map change stay set until released
module key_mapper (
	input  logic        clk_sys,
	input  logic        reset,
	input  logic [10:0] ps2_key,
	input  logic        tank_mode,
	output logic [7:0]  key_p1,
	output logic [7:0]  key_p2,
	output logic [7:0]  key_p3,
	output logic [3:0]  key_coin
);

	typedef enum logic {
		map_std  = 1'b0,  // Joystick games
		map_tank = 1'b1   // Twin-track tank
	} key_map_t;

	key_map_t   key_map;
	logic       toggle_q;   // Last seen event toggle
	logic       key_event;
	logic       pressed;
	logic [8:0] key_code;   // Extended flag on top

	assign key_map   = tank_mode ? map_tank : map_std;
	assign key_event = (ps2_key[10] != toggle_q);
	assign pressed   = ps2_key[9];
	assign key_code  = ps2_key[8:0];

	// ############################################################
	// Held key bits
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			toggle_q <= ps2_key[10]; // No event straight out of reset
			key_p1   <= 8'h00;
			key_p2   <= 8'h00;
			key_p3   <= 8'h00;
			key_coin <= 4'h0;
		end else begin
			toggle_q <= ps2_key[10];
			if (key_event && key_map == map_tank) begin
				case (key_code)
					9'h023: key_p1[7]   <= pressed; // R back (D)
					9'h01B: key_p1[6]   <= pressed; // L back (S)
					9'h024: key_p1[5]   <= pressed; // R forward (E)
					9'h01D: key_p1[4]   <= pressed; // L forward (W)
					9'h02D: key_p1[3]   <= pressed; // R thumb (R)
					9'h015: key_p1[2]   <= pressed; // L thumb (Q)
					9'h02B: key_p1[1]   <= pressed; // R trigger (F)
					9'h01C: key_p1[0]   <= pressed; // L trigger (A)
					9'h042: key_p2[7]   <= pressed; // K
					9'h03B: key_p2[6]   <= pressed; // J
					9'h043: key_p2[5]   <= pressed; // I
					9'h03C: key_p2[4]   <= pressed; // U
					9'h044: key_p2[3]   <= pressed; // O
					9'h035: key_p2[2]   <= pressed; // Y
					9'h04B: key_p2[1]   <= pressed; // L
					9'h033: key_p2[0]   <= pressed; // H
					9'h016: key_p3[0]   <= pressed; // P1 start (1)
					9'h01E: key_p3[1]   <= pressed; // P2 start (2)
					9'h02E: key_coin[0] <= pressed; // 5
					9'h036: key_coin[1] <= pressed; // 6
					default: ;
				endcase
			end else if (key_event) begin
				// Arrows match with or without the extended prefix
				casez (key_code)
					9'b?_0111_0101: key_p1[7]   <= pressed; // Up
					9'b?_0111_0010: key_p1[6]   <= pressed; // Down
					9'b?_0110_1011: key_p1[5]   <= pressed; // Left
					9'b?_0111_0100: key_p1[4]   <= pressed; // Right
					9'h014:         key_p1[1]   <= pressed; // Fire (Ctrl)
					9'h011:         key_p1[0]   <= pressed; // Magic (Alt)
					9'h02D:         key_p2[7]   <= pressed; // R
					9'h02B:         key_p2[6]   <= pressed; // F
					9'h023:         key_p2[5]   <= pressed; // D
					9'h034:         key_p2[4]   <= pressed; // G
					9'h01C:         key_p2[1]   <= pressed; // A
					9'h01B:         key_p2[0]   <= pressed; // S
					9'h02E:         key_coin[0] <= pressed; // 5
					9'h036:         key_coin[1] <= pressed; // 6
					9'h03D:         key_coin[2] <= pressed; // 7
					9'h03E:         key_coin[3] <= pressed; // 8
					default: ;
				endcase
			end
		end
	end

	// Key bits move only one cycle after an event
	a_keys_on_event: assert property (@(posedge clk_sys) disable iff (reset)
		!$stable({key_p1, key_p2, key_p3, key_coin}) |-> $past(key_event))
		else $error("FAILED %0t key bits: expected stable, got a change", $time);

endmodule

//--- hdl/player_ports.sv
// All ports active low and registered; joystick bits above 9 are ignored
module player_ports (
	input  logic        clk_sys,
	input  logic        reset,
	input  logic        tank_mode,
	input  logic [7:0]  key_p1,
	input  logic [7:0]  key_p2,
	input  logic [7:0]  key_p3,
	input  logic [3:0]  key_coin,
	input  logic [15:0] joy0,
	input  logic [15:0] joy1,
	input  logic [15:0] joy2,
	input  logic [15:0] joy3,
	input  logic        service,
	output logic [7:0]  port_p1,
	output logic [7:0]  port_p2,
	output logic [7:0]  port_p3,
	output logic [7:0]  port_p4,
	output logic [4:0]  port_sys
);

	logic [3:0] trk0;      // Tracks from joy0
	logic [3:0] trk1;      // Tracks from joy1
	logic [7:0] p1_next;
	logic [7:0] p2_next;
	logic [7:0] p3_next;
	logic [7:0] p4_next;
	logic [4:0] sys_next;

	// ############################################################
	// Stick to tracks, dir is {up, down, left, right}
	// Result is {r_back, l_back, r_fwd, l_fwd}, matching port bits 7..4
	function automatic logic [3:0] tank_tracks(input logic [3:0] dir);
		case (dir)
			4'b1000: return 4'b0011; // Up, both forward
			4'b0100: return 4'b1100; // Down, both back
			4'b0010: return 4'b0110; // Left, spin
			4'b0001: return 4'b1001; // Right, spin
			4'b1010: return 4'b0010; // Up left
			4'b1001: return 4'b0001; // Up right
			4'b0110: return 4'b1000; // Down left
			4'b0101: return 4'b0100; // Down right
			default: return 4'b0000;
		endcase
	endfunction

	assign trk0 = tank_tracks(joy0[3:0]);
	assign trk1 = tank_tracks(joy1[3:0]);

	// Port composition
	always_comb begin
		if (tank_mode) begin
			p1_next = ~(key_p1 | {trk0, joy0[7:4]});
			p2_next = ~(key_p2 | {trk1, joy1[7:4]});
			p3_next = ~(key_p3 | {6'b00_0000, joy1[9], joy0[9]}); // Start buttons
			p4_next = ~8'h00; // No keys map here
		end else begin
			// Directions high, buttons low
			p1_next = ~(key_p1 | {joy0[3:0], joy0[7:4]});
			p2_next = ~(key_p2 | {joy1[3:0], joy1[7:4]});
			p3_next = ~(key_p3 | {joy2[3:0], joy2[7:4]});
			p4_next = ~{joy3[3:0], joy3[7:4]};
		end
		sys_next = ~{service,
				key_coin[0] | joy0[8],
				key_coin[1] | joy1[8],
				key_coin[2] | joy2[8],
				key_coin[3] | joy3[8]};
	end

	// ############################################################
	// Output registers, idle is all ones
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			port_p1  <= 8'hFF;
			port_p2  <= 8'hFF;
			port_p3  <= 8'hFF;
			port_p4  <= 8'hFF;
			port_sys <= 5'h1F;
		end else begin
			port_p1  <= p1_next;
			port_p2  <= p2_next;
			port_p3  <= p3_next;
			port_p4  <= p4_next;
			port_sys <= sys_next;
		end
	end

	// Inactive ports seen by the game right after reset
	a_ports_idle: assert property (@(posedge clk_sys)
		reset |=> (port_p1 == 8'hFF && port_p2 == 8'hFF && port_p3 == 8'hFF &&
			port_p4 == 8'hFF && port_sys == 5'h1F))
		else $error("FAILED %0t ports: expected all ones after reset", $time);

endmodule

//--- hdl/rom_download_assembler.sv
// Assumes file 0 arrives in ascending address order; bytes of one unit must not be interleaved
`include "sys1_settings.svh"

module rom_download_assembler
	import sys1_pkg::*;
(
	input  logic                        clk_sys,
	input  logic                        reset,
	input  logic                        ioctl_download,
	input  logic                        ioctl_wr,
	input  logic [7:0]                  ioctl_index,
	input  logic [`SYS1_DL_ADDR_W-1:0]  ioctl_addr,
	input  logic [7:0]                  ioctl_dout,
	output logic                        rom_we,
	output logic [`SYS1_ROM_ADDR_W-1:0] rom_addr,
	output logic [31:0]                 rom_data,
	output rom_region_t                 rom_region
);

	rom_region_t byte_region;     // Region of current byte
	logic        rom_byte;        // Valid byte of file 0
	logic        unit_done;       // Byte closes a unit
	logic [23:0] acc_bytes;       // Last three bytes, newest low
	logic [31:0] unit_data;

	function automatic logic in_range(
		input logic [`SYS1_DL_ADDR_W-1:0] addr,
		input logic [`SYS1_DL_ADDR_W-1:0] base,
		input logic [`SYS1_DL_ADDR_W-1:0] limit
	);
		return (addr >= base) && (addr <= limit);
	endfunction

	// ############################################################
	// Address decode
	always_comb begin
		byte_region = rgn_none; // Filler by default
		if (in_range(ioctl_addr, `SYS1_GFX_BASE, `SYS1_GFX_LIMIT)) begin
			byte_region = rgn_gfx;
		end else if (in_range(ioctl_addr, `SYS1_PROG0_BASE, `SYS1_PROG0_LIMIT) ||
				in_range(ioctl_addr, `SYS1_PROG1_BASE, `SYS1_PROG1_LIMIT) ||
				in_range(ioctl_addr, `SYS1_PROG2_BASE, `SYS1_PROG2_LIMIT)) begin
			byte_region = rgn_prog;
		end else if (in_range(ioctl_addr, `SYS1_AUDIO_BASE, `SYS1_AUDIO_LIMIT)) begin
			byte_region = rgn_audio;
		end else if (in_range(ioctl_addr, `SYS1_CHAR_BASE, `SYS1_CHAR_LIMIT)) begin
			byte_region = rgn_char;
		end
	end

	assign rom_byte = ioctl_wr && ioctl_download && (ioctl_index == `SYS1_IDX_ROM);

	// Unit completion and packing, first byte in the high lane
	always_comb begin
		unit_done = 1'b0;
		unit_data = {acc_bytes, ioctl_dout};
		case (byte_region)
			rgn_gfx: begin
				unit_done = (ioctl_addr[1:0] == 2'b11); // Fourth byte of dword
			end
			rgn_prog: begin
				unit_done = ioctl_addr[0];               // Odd byte closes word
				unit_data = {16'h0000, acc_bytes[7:0], ioctl_dout};
			end
			rgn_audio, rgn_char: begin
				unit_done = 1'b1;
				unit_data = {24'h00_0000, ioctl_dout};
			end
			default: unit_done = 1'b0;
		endcase
	end

	// ############################################################
	// Registers
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			rom_we     <= 1'b0;
			rom_region <= rgn_none;
		end else begin
			rom_we <= rom_byte && unit_done; // One-cycle strobe
			if (rom_byte && unit_done)
				rom_region <= byte_region;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (rom_byte)
			acc_bytes <= {acc_bytes[15:0], ioctl_dout}; // Filler shifts too
		if (rom_byte && unit_done) begin
			rom_addr <= ioctl_addr[`SYS1_DL_ADDR_W-1:2];
			rom_data <= unit_data;
		end
	end

	// Strobe always carries a real region
	a_we_region: assert property (@(posedge clk_sys) disable iff (reset)
		rom_we |-> (rom_region != rgn_none))
		else $error("FAILED %0t rom_region: expected a ROM, got rgn_none", $time);

	// Word and dword units need at least two bytes, so never back to back
	a_we_spacing: assert property (@(posedge clk_sys) disable iff (reset)
		rom_we && (rom_region == rgn_gfx || rom_region == rgn_prog)
		|=> !(rom_we && rom_region == $past(rom_region)))
		else $error("FAILED %0t rom_we: expected 0, got 1", $time);

endmodule

//--- hdl/sys1_input_top.sv
// Single clock domain; rom_we replaces the SDRAM write and has no ready or wait
`include "sys1_settings.svh"

module sys1_input_top
	import sys1_pkg::*;
(
	input  logic                         clk_sys,
	input  logic                         reset,
	// Host download
	input  logic                         ioctl_download,
	input  logic                         ioctl_wr,
	input  logic [7:0]                   ioctl_index,
	input  logic [`SYS1_DL_ADDR_W-1:0]   ioctl_addr,
	input  logic [7:0]                   ioctl_dout,
	// Controls
	input  logic [10:0]                  ps2_key,
	input  logic [15:0]                  joy0,
	input  logic [15:0]                  joy1,
	input  logic [15:0]                  joy2,
	input  logic [15:0]                  joy3,
	input  logic                         service,
	// ROM writes
	output logic                         rom_we,
	output logic [`SYS1_ROM_ADDR_W-1:0]  rom_addr,
	output logic [31:0]                  rom_data,
	output rom_region_t                  rom_region,
	// Configuration
	output logic [8*`SYS1_DIP_BYTES-1:0] dip_switches,
	output game_type_t                   game_type,
	// Game ports, active low
	output logic [7:0]                   port_p1,
	output logic [7:0]                   port_p2,
	output logic [7:0]                   port_p3,
	output logic [7:0]                   port_p4,
	output logic [4:0]                   port_sys
);

	logic       tank_mode;
	logic [7:0] key_p1;
	logic [7:0] key_p2;
	logic [7:0] key_p3;
	logic [3:0] key_coin;

	// ############################################################
	rom_download_assembler u_rom_dl (
		.clk_sys(clk_sys), .reset(reset),
		.ioctl_download(ioctl_download), .ioctl_wr(ioctl_wr),
		.ioctl_index(ioctl_index), .ioctl_addr(ioctl_addr), .ioctl_dout(ioctl_dout),
		.rom_we(rom_we), .rom_addr(rom_addr), .rom_data(rom_data), .rom_region(rom_region)
	);

	config_capture u_config (
		.clk_sys(clk_sys), .reset(reset), .ioctl_wr(ioctl_wr),
		.ioctl_index(ioctl_index), .ioctl_addr(ioctl_addr), .ioctl_dout(ioctl_dout),
		.dip_switches(dip_switches), .game_type(game_type), .tank_mode(tank_mode)
	);

	key_mapper u_keys (
		.clk_sys(clk_sys), .reset(reset), .ps2_key(ps2_key), .tank_mode(tank_mode),
		.key_p1(key_p1), .key_p2(key_p2), .key_p3(key_p3), .key_coin(key_coin)
	);

	player_ports u_ports (
		.clk_sys(clk_sys), .reset(reset), .tank_mode(tank_mode),
		.key_p1(key_p1), .key_p2(key_p2), .key_p3(key_p3), .key_coin(key_coin),
		.joy0(joy0), .joy1(joy1), .joy2(joy2), .joy3(joy3), .service(service),
		.port_p1(port_p1), .port_p2(port_p2), .port_p3(port_p3), .port_p4(port_p4),
		.port_sys(port_sys)
	);

endmodule

//--- hdl/sys1_pkg.sv
// Types only; rom_region_t fits 3 bits and game codes are not range checked
package sys1_pkg;

	// ############################################################
	// ROM region of a download write

	// rgn_none marks filler and idle, never a real write
	typedef enum logic [2:0] {
		rgn_none  = 3'd0,
		rgn_gfx   = 3'd1,  // Video ROMs, dword wide
		rgn_prog  = 3'd2,  // CPU ROMs, word wide
		rgn_audio = 3'd3,  // Sound CPU ROMs, byte wide
		rgn_char  = 3'd4   // Alphanumerics ROM, byte wide
	} rom_region_t;

	// ############################################################
	// Game type

	// Plain byte
	// Codes follow the slapstic numbering of the original boards
	// plus 118 for the tank game
	typedef logic [7:0] game_type_t;

endpackage

//--- hdl/sys1_settings.svh
// Region limits assume the System-1 download layout; changing them moves ROM writes, not widths
`ifndef SYS1_SETTINGS_SVH
`define SYS1_SETTINGS_SVH

// ############################################################
// Widths
`define SYS1_DL_ADDR_W     25          // Host byte address
`define SYS1_ROM_ADDR_W    23          // Dword address to external memory
`define SYS1_DIP_BYTES     8

// Host file indices
`define SYS1_IDX_ROM       8'd0
`define SYS1_IDX_GAME      8'd1
`define SYS1_IDX_DIP       8'd254

// Game codes
`define SYS1_GAME_TANK     8'd118      // Tank controls
`define SYS1_GAME_DEFAULT  8'd105

// ############################################################
// Download address map, inclusive limits; gaps are filler
`define SYS1_GFX_BASE      25'h000000
`define SYS1_GFX_LIMIT     25'h0BFFFF
`define SYS1_PROG0_BASE    25'h0C0000  // 9A/9B
`define SYS1_PROG0_LIMIT   25'h0CFFFF
`define SYS1_PROG1_BASE    25'h0F0000  // 10A/10B
`define SYS1_PROG1_LIMIT   25'h0F7FFF
`define SYS1_PROG2_BASE    25'h100000  // 7A/7B up to 3A/3B
`define SYS1_PROG2_LIMIT   25'h13FFFF
`define SYS1_AUDIO_BASE    25'h140000
`define SYS1_AUDIO_LIMIT   25'h14BFFF
`define SYS1_CHAR_BASE     25'h14C000
`define SYS1_CHAR_LIMIT    25'h14FFFF

`endif

//--- run_sim.sh
#!/bin/sh
# Verilator build and run from the project root; the status follows the log search
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_sys1_input \
	-f sys1_input_top.f -Mdir obj_dir -o tb_sys1_input &&
{ ./obj_dir/tb_sys1_input > sim.log 2>&1 || true; } &&
cat sim.log &&
grep -qx "No errors" sim.log &&
echo "PASS" ||
{ echo "FAIL"; exit 1; }

//--- sys1_input_top.f
+incdir+hdl
hdl/sys1_pkg.sv
hdl/rom_download_assembler.sv
hdl/config_capture.sv
hdl/key_mapper.sv
hdl/player_ports.sv
hdl/sys1_input_top.sv
testbench/tb_sys1_checks.sv
testbench/tb_sys1_input.sv

//--- testbench/tb_sys1_checks.sv
// Follows the top-level timing in cycles; the ROM model expects ioctl_download high during file 0
`include "sys1_settings.svh"

module tb_sys1_checks
	import sys1_pkg::*;
(
	input  logic                         clk_sys,
	input  logic                         reset,
	input  logic                         ioctl_download,
	input  logic                         ioctl_wr,
	input  logic [7:0]                   ioctl_index,
	input  logic [`SYS1_DL_ADDR_W-1:0]   ioctl_addr,
	input  logic [7:0]                   ioctl_dout,
	input  logic [10:0]                  ps2_key,
	input  logic [15:0]                  joy0, joy1, joy2, joy3,
	input  logic                         service,
	input  logic                         rom_we,
	input  logic [`SYS1_ROM_ADDR_W-1:0]  rom_addr,
	input  logic [31:0]                  rom_data,
	input  rom_region_t                  rom_region,
	input  logic [8*`SYS1_DIP_BYTES-1:0] dip_switches,
	input  game_type_t                   game_type,
	input  logic [7:0]                   port_p1, port_p2, port_p3, port_p4,
	input  logic [4:0]                   port_sys,
	output logic                         error_seen
);
	timeunit 1ns;
	timeprecision 1ps;

	logic [23:0]                  hist;        // Last three file-0 bytes
	logic                         exp_we;      // Expected strobe, one cycle late
	logic [`SYS1_ROM_ADDR_W-1:0]  exp_addr;
	logic [31:0]                  exp_data;
	rom_region_t                  exp_region;
	logic [8*`SYS1_DIP_BYTES-1:0] exp_dip;
	game_type_t                   exp_game;
	logic                         rom_byte;
	logic                         in_prog;     // Any of the three CPU ranges
	logic                         clk_seen;
	logic                         toggle_seen; // Previous event toggle
	logic                         key_evt;
	logic                         tank;
	logic                         up_press, up_release, k7_press, d_press;

	initial begin
		error_seen = 1'b0;
		clk_seen   = 1'b0;
	end

	task automatic report_mismatch(input string name, input logic [63:0] expected,
			input logic [63:0] actual);
		$display("FAILED %0t %s: expected %0h, got %0h", $time, name, expected, actual);
		error_seen = 1'b1; // Top level stops the run
	endtask

	// ############################################################
	// Reference model from the address map and unit rules
	assign rom_byte = ioctl_wr && ioctl_download && (ioctl_index == `SYS1_IDX_ROM);
	assign in_prog  = (ioctl_addr >= `SYS1_PROG0_BASE && ioctl_addr <= `SYS1_PROG0_LIMIT) ||
			(ioctl_addr >= `SYS1_PROG1_BASE && ioctl_addr <= `SYS1_PROG1_LIMIT) ||
			(ioctl_addr >= `SYS1_PROG2_BASE && ioctl_addr <= `SYS1_PROG2_LIMIT);

	always @(posedge clk_sys) begin
		clk_seen    <= 1'b1;
		toggle_seen <= ps2_key[10];
		if (reset) begin
			exp_we   <= 1'b0;
			exp_dip  <= '0;
			exp_game <= `SYS1_GAME_DEFAULT;
		end else begin
			exp_we <= 1'b0;
			if (rom_byte) begin
				hist     <= {hist[15:0], ioctl_dout};   // Filler bytes shift as well
				exp_addr <= ioctl_addr[`SYS1_DL_ADDR_W-1:2];
				if (ioctl_addr <= `SYS1_GFX_LIMIT) begin
					exp_we     <= (ioctl_addr[1:0] == 2'b11); // Dword, first byte high
					exp_region <= rgn_gfx;
					exp_data   <= {hist, ioctl_dout};
				end else if (in_prog) begin
					exp_we     <= ioctl_addr[0];             // Word on odd byte
					exp_region <= rgn_prog;
					exp_data   <= {16'h0000, hist[7:0], ioctl_dout};
				end else if (ioctl_addr >= `SYS1_AUDIO_BASE &&
						ioctl_addr <= `SYS1_CHAR_LIMIT) begin
					exp_we     <= 1'b1;                      // Byte units
					exp_region <= (ioctl_addr >= `SYS1_CHAR_BASE) ? rgn_char : rgn_audio;
					exp_data   <= {24'h00_0000, ioctl_dout};
				end
			end
			if (ioctl_wr && ioctl_index == `SYS1_IDX_DIP && ioctl_addr < 25'd8)
				exp_dip[{ioctl_addr[2:0], 3'b000} +: 8] <= ioctl_dout;
			if (ioctl_wr && ioctl_index == `SYS1_IDX_GAME)
				exp_game <= ioctl_dout;
		end
	end

	// Key events of interest
	assign tank       = (exp_game == `SYS1_GAME_TANK);
	assign key_evt    = (ps2_key[10] != toggle_seen);
	assign up_press   = key_evt && ps2_key[9] && ps2_key[8:0] == 9'h175 && !tank;
	assign up_release = key_evt && !ps2_key[9] && ps2_key[8:0] == 9'h175 && !tank && !joy0[3];
	assign k7_press   = key_evt && ps2_key[9] && ps2_key[8:0] == 9'h03D && !tank;
	assign d_press    = key_evt && ps2_key[9] && ps2_key[8:0] == 9'h023 && tank;

	// ############################################################
	// Download and configuration
	a_rom_we: assert property (@(posedge clk_sys) disable iff (reset) rom_we == exp_we)
		else report_mismatch("rom_we", 64'($sampled(exp_we)), 64'($sampled(rom_we)));
	a_rom_unit: assert property (@(posedge clk_sys) disable iff (reset)
			exp_we |-> {rom_addr, rom_data, rom_region} == {exp_addr, exp_data, exp_region})
		else report_mismatch("rom_addr/rom_data/rom_region",
			64'($sampled({exp_addr, exp_data, exp_region})),
			64'($sampled({rom_addr, rom_data, rom_region})));
	a_dip: assert property (@(posedge clk_sys) disable iff (reset) dip_switches == exp_dip)
		else report_mismatch("dip_switches", $sampled(exp_dip), $sampled(dip_switches));
	a_game: assert property (@(posedge clk_sys) disable iff (reset) game_type == exp_game)
		else report_mismatch("game_type", 64'($sampled(exp_game)), 64'($sampled(game_type)));

	// Keyboard, two cycles to the port
	a_key_up: assert property (@(posedge clk_sys) disable iff (reset)
			$past(up_press, 2) |-> !port_p1[7])
		else report_mismatch("port_p1[7]", 64'd0, 64'($sampled(port_p1[7])));
	a_key_up_off: assert property (@(posedge clk_sys) disable iff (reset)
			$past(up_release, 2) |-> port_p1[7])
		else report_mismatch("port_p1[7]", 64'd1, 64'($sampled(port_p1[7])));
	a_key_coin: assert property (@(posedge clk_sys) disable iff (reset)
			$past(k7_press, 2) |-> !port_sys[1])                 // Coin 3
		else report_mismatch("port_sys[1]", 64'd0, 64'($sampled(port_sys[1])));
	a_tank_key: assert property (@(posedge clk_sys) disable iff (reset)
			$past(d_press, 2) |-> !port_p1[7])                   // Right track back
		else report_mismatch("port_p1[7]", 64'd0, 64'($sampled(port_p1[7])));

	// Tank sticks, one cycle; bits 7..4 are r_back, l_back, r_fwd, l_fwd
	a_tank_up: assert property (@(posedge clk_sys) disable iff (reset)
			$past(tank && joy0[3:0] == 4'b1000) |-> port_p1[5:4] == 2'b00)
		else report_mismatch("port_p1[5:4]", 64'd0, 64'($sampled(port_p1[5:4])));
	a_tank_left: assert property (@(posedge clk_sys) disable iff (reset)
			$past(tank && joy0[3:0] == 4'b0010) |-> port_p1[6:5] == 2'b00)
		else report_mismatch("port_p1[6:5]", 64'd0, 64'($sampled(port_p1[6:5])));
	a_tank_start: assert property (@(posedge clk_sys) disable iff (reset)
			$past(tank && joy1[9]) |-> !port_p3[1])
		else report_mismatch("port_p3[1]", 64'd0, 64'($sampled(port_p3[1])));

	// System port and reset state
	a_service: assert property (@(posedge clk_sys) disable iff (reset)
			port_sys[4] == !$past(service))
		else report_mismatch("port_sys[4]", 64'(!$past(service)), 64'($sampled(port_sys[4])));
	a_joy_coin: assert property (@(posedge clk_sys) disable iff (reset)
			(port_sys[3:0] & $past({joy0[8], joy1[8], joy2[8], joy3[8]})) == 4'h0)
		else report_mismatch("port_sys[3:0]", 64'($past({~joy0[8], ~joy1[8], ~joy2[8], ~joy3[8]})),
			64'($sampled(port_sys[3:0])));
	a_reset_idle: assert property (@(posedge clk_sys) (clk_seen && $past(reset)) |->
			{port_p1, port_p2, port_p3, port_p4, port_sys, rom_we} == 38'h3F_FFFF_FFFE)
		else report_mismatch("ports/rom_we after reset", 64'h3F_FFFF_FFFE,
			64'($sampled({port_p1, port_p2, port_p3, port_p4, port_sys, rom_we})));

endmodule

//--- testbench/tb_sys1_input.sv
// Inputs change on the falling edge only; download bytes come from $random with a fixed seed
`include "sys1_settings.svh"

module tb_sys1_input
	import sys1_pkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int dl_cycles  = 40;  // ROM, DIP and game downloads
	localparam int key_cycles = 70;  // Keyboard, tank and system port
	localparam int rst_cycles = 20;  // Both resets
	localparam int limit_ns   = 2 * 10 * (dl_cycles + key_cycles + rst_cycles); // Twice the run

	logic                         clk_sys, reset, service, error_seen;
	logic                         ioctl_download, ioctl_wr;
	logic [7:0]                   ioctl_index, ioctl_dout;
	logic [`SYS1_DL_ADDR_W-1:0]   ioctl_addr;
	logic [10:0]                  ps2_key;
	logic [15:0]                  joy0, joy1, joy2, joy3;
	logic                         rom_we;
	logic [`SYS1_ROM_ADDR_W-1:0]  rom_addr;
	logic [31:0]                  rom_data;
	rom_region_t                  rom_region;
	logic [8*`SYS1_DIP_BYTES-1:0] dip_switches;
	game_type_t                   game_type;
	logic [7:0]                   port_p1, port_p2, port_p3, port_p4;
	logic [4:0]                   port_sys;
	integer                       seed;

	sys1_input_top dut (.*);
	tb_sys1_checks checks (.*);  // Same pin names as the DUT

	always #5 clk_sys = ~clk_sys; // 10 ns period

	// ############################################################
	// Run limits
	always @(posedge error_seen) begin
		$display("Errors found");
		$fatal(1, "Run stopped at the first failed check");
	end

	initial begin
		#(limit_ns);
		$display("Errors found");
		$fatal(1, "Timeout: stimulus did not reach its end in time");
	end

	function automatic logic [7:0] rand_byte();
		logic [31:0] r;
		r = $random(seed);
		return r[7:0];
	endfunction

	task automatic idle(input int cycles);
		repeat (cycles) @(negedge clk_sys);
	endtask

	// Back to back when called in a row
	task automatic host_byte(input logic [7:0] index, input logic [`SYS1_DL_ADDR_W-1:0] addr,
			input logic [7:0] data);
		@(negedge clk_sys);
		ioctl_wr    = 1'b1;
		ioctl_index = index;
		ioctl_addr  = addr;
		ioctl_dout  = data;
	endtask

	task automatic host_stop();
		@(negedge clk_sys);
		ioctl_wr = 1'b0;
		idle(3);
	endtask

	task automatic key_event(input logic pressed, input logic [8:0] code);
		@(negedge clk_sys);
		ps2_key = {~ps2_key[10], pressed, code}; // Toggle marks the event
		idle(4);
	endtask

	task automatic set_controls(input logic [15:0] j0, input logic [15:0] j1,
			input logic [15:0] j2, input logic [15:0] j3, input logic svc);
		@(negedge clk_sys);
		joy0    = j0;
		joy1    = j1;
		joy2    = j2;
		joy3    = j3;
		service = svc;
		idle(3);
	endtask

	// ############################################################
	// Stimulus
	initial begin
		seed           = 32'h0122_a46f;
		clk_sys        = 1'b0;
		reset          = 1'b1;
		ioctl_download = 1'b0;
		ioctl_wr       = 1'b0;
		ioctl_index    = 8'h00;
		ioctl_addr     = '0;
		ioctl_dout     = 8'h00;
		ps2_key        = 11'h000;
		joy0           = 16'h0000;
		joy1           = 16'h0000;
		joy2           = 16'h0000;
		joy3           = 16'h0000;
		service        = 1'b0;
		repeat (5) @(posedge clk_sys);
		@(negedge clk_sys);
		reset          = 1'b0;
		ioctl_download = 1'b1;

		for (int i = 0; i < 4; i++)
			host_byte(`SYS1_IDX_ROM, 25'(i), rand_byte());  // One graphics dword
		host_stop();
		host_byte(`SYS1_IDX_ROM, 25'h0C0000, rand_byte()); // Program word
		host_byte(`SYS1_IDX_ROM, 25'h0C0001, rand_byte());
		for (int i = 0; i < 4; i++)
			host_byte(`SYS1_IDX_ROM, 25'h0D0000 + 25'(i), rand_byte()); // Filler
		host_byte(`SYS1_IDX_ROM, 25'h140000, rand_byte()); // Audio
		host_byte(`SYS1_IDX_ROM, 25'h14C000, rand_byte()); // Character
		host_stop();

		for (int i = 0; i < 8; i++)
			host_byte(`SYS1_IDX_DIP, 25'(i), rand_byte());
		host_byte(`SYS1_IDX_DIP, 25'd8, 8'hA5);            // Past the last lane
		host_stop();

		key_event(1'b1, 9'h175);   // Extended up arrow
		key_event(1'b0, 9'h175);
		key_event(1'b1, 9'h03D);   // Key 7, coin 3
		key_event(1'b0, 9'h03D);

		host_byte(`SYS1_IDX_GAME, 25'd0, `SYS1_GAME_TANK);
		host_stop();
		set_controls(16'h0008, 16'h0000, 16'h0000, 16'h0000, 1'b0); // Up
		set_controls(16'h0002, 16'h0000, 16'h0000, 16'h0000, 1'b0); // Left
		set_controls(16'h0000, 16'h0000, 16'h0000, 16'h0000, 1'b0);
		key_event(1'b1, 9'h023);   // D
		key_event(1'b0, 9'h023);
		set_controls(16'h0000, 16'h0200, 16'h0000, 16'h0000, 1'b0); // P2 start

		set_controls(16'h0000, 16'h0000, 16'h0000, 16'h0000, 1'b1); // Service
		set_controls(16'h0100, 16'h0000, 16'h0000, 16'h0000, 1'b0); // Coin 1
		set_controls(16'h0000, 16'h0100, 16'h0000, 16'h0000, 1'b0); // Coin 2
		set_controls(16'h0000, 16'h0000, 16'h0100, 16'h0000, 1'b0); // Coin 3
		set_controls(16'h0000, 16'h0000, 16'h0000, 16'h0100, 1'b0); // Coin 4
		set_controls(16'h0000, 16'h0000, 16'h0000, 16'h0000, 1'b0);

		@(negedge clk_sys);
		reset = 1'b1;              // Second reset, 5 cycles
		idle(5);
		reset = 1'b0;
		idle(3);

		if (error_seen) begin
			$display("Errors found");
			$fatal(1, "A check failed before the end of the stimulus");
		end else begin
			$display("No errors");
			$finish;
		end
	end

endmodule
